// File: include/rsrc_defs.svh
`ifndef RSRC_DEFS_SVH
`define RSRC_DEFS_SVH

// ------------------------------
// dispatch and branch tags
// ------------------------------

// slots per dispatch group
`define RSRC_DISP_SIZE 2

// branch tag pool
`define RSRC_BRTAG_NUM 4
// log2 of the pool size
`define RSRC_BRTAG_W 2

// ------------------------------
// back-end queue depths
// ------------------------------

`define RSRC_ROB_DEPTH 16
`define RSRC_ALU_DEPTH 8
`define RSRC_LDQ_DEPTH 8
`define RSRC_STQ_DEPTH 8
// one branch unit entry per tag
`define RSRC_BRU_DEPTH `RSRC_BRTAG_NUM

// config address, 0..4 select rob, alu, ldq, stq, bru
`define RSRC_CFG_ADDR_W 3

// credit counts, limits and per-group counts
`define RSRC_CNT_W 5

`endif

// File: source/rsrc_pkg.sv
`include "rsrc_defs.svh"

package rsrc_pkg;

  // top bit of the commit word selects the view
  localparam logic KIND_COMMIT = 1'b0;
  localparam logic KIND_FLUSH  = 1'b1;

  // 8-bit commit word, decoded either as a commit or as a flush
  typedef union packed {
    // commit view releases the tags of committed branches
    struct packed {
      logic                                          kind;
      logic [`RSRC_DISP_SIZE-1:0]                    is_br;
      logic [`RSRC_DISP_SIZE-1:0][`RSRC_BRTAG_W-1:0] tag;
      logic                                          pad;
    } cmt;
    // flush view frees one tag and cancels this cycle's dispatch
    struct packed {
      logic                     kind;
      logic                     valid;
      logic [`RSRC_BRTAG_W-1:0] tag;
      logic [3:0]               pad;
    } flush;
  } commit_word_u;

endpackage

// File: source/rsrc_cfg_regs.sv
`timescale 1ns/1ps
`include "rsrc_defs.svh"

module rsrc_cfg_regs (
  input  logic                        i_clk,
  input  logic                        i_reset_n,
  input  logic                        i_cfg_we,
  input  logic [`RSRC_CFG_ADDR_W-1:0] i_cfg_addr,
  input  logic [`RSRC_CNT_W-1:0]      i_cfg_wdata,
  output logic [`RSRC_CNT_W-1:0]      o_rob_limit,
  output logic [`RSRC_CNT_W-1:0]      o_alu_limit,
  output logic [`RSRC_CNT_W-1:0]      o_ldq_limit,
  output logic [`RSRC_CNT_W-1:0]      o_stq_limit,
  output logic [`RSRC_CNT_W-1:0]      o_bru_limit
);

  localparam int ADDR_W = `RSRC_CFG_ADDR_W;
  localparam int CNT_W  = `RSRC_CNT_W;

  localparam logic [ADDR_W-1:0] ADDR_ROB = ADDR_W'(0);
  localparam logic [ADDR_W-1:0] ADDR_ALU = ADDR_W'(1);
  localparam logic [ADDR_W-1:0] ADDR_LDQ = ADDR_W'(2);
  localparam logic [ADDR_W-1:0] ADDR_STQ = ADDR_W'(3);
  localparam logic [ADDR_W-1:0] ADDR_BRU = ADDR_W'(4);

  localparam logic [CNT_W-1:0] ROB_DEPTH = CNT_W'(`RSRC_ROB_DEPTH);
  localparam logic [CNT_W-1:0] ALU_DEPTH = CNT_W'(`RSRC_ALU_DEPTH);
  localparam logic [CNT_W-1:0] LDQ_DEPTH = CNT_W'(`RSRC_LDQ_DEPTH);
  localparam logic [CNT_W-1:0] STQ_DEPTH = CNT_W'(`RSRC_STQ_DEPTH);
  localparam logic [CNT_W-1:0] BRU_DEPTH = CNT_W'(`RSRC_BRU_DEPTH);

  logic [CNT_W-1:0] r_rob_limit;
  logic [CNT_W-1:0] r_alu_limit;
  logic [CNT_W-1:0] r_ldq_limit;
  logic [CNT_W-1:0] r_stq_limit;
  logic [CNT_W-1:0] r_bru_limit;

  // a limit above the real queue depth is cut back to the depth
  function automatic logic [CNT_W-1:0] clamp(input logic [CNT_W-1:0] val,
                                             input logic [CNT_W-1:0] depth);
    return (val > depth) ? depth : val;
  endfunction

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_rob_limit <= ROB_DEPTH;
      r_alu_limit <= ALU_DEPTH;
      r_ldq_limit <= LDQ_DEPTH;
      r_stq_limit <= STQ_DEPTH;
      r_bru_limit <= BRU_DEPTH;
    end else if (i_cfg_we) begin
      case (i_cfg_addr)
        ADDR_ROB: r_rob_limit <= clamp(i_cfg_wdata, ROB_DEPTH);
        ADDR_ALU: r_alu_limit <= clamp(i_cfg_wdata, ALU_DEPTH);
        ADDR_LDQ: r_ldq_limit <= clamp(i_cfg_wdata, LDQ_DEPTH);
        ADDR_STQ: r_stq_limit <= clamp(i_cfg_wdata, STQ_DEPTH);
        ADDR_BRU: r_bru_limit <= clamp(i_cfg_wdata, BRU_DEPTH);
        // unmapped addresses, write dropped
        default: ;
      endcase
    end
  end

  assign o_rob_limit = r_rob_limit;
  assign o_alu_limit = r_alu_limit;
  assign o_ldq_limit = r_ldq_limit;
  assign o_stq_limit = r_stq_limit;
  assign o_bru_limit = r_bru_limit;

endmodule

// File: source/credit_counter.sv
`timescale 1ns/1ps
`include "rsrc_defs.svh"

module credit_counter #(
  parameter int MAX_CREDITS = 8
) (
  input  logic                   i_clk,
  input  logic                   i_reset_n,
  // acquire from a fired dispatch group
  input  logic                   i_get_credit,
  input  logic [`RSRC_CNT_W-1:0] i_credit_val,
  // return from the queue
  input  logic                   i_ret_valid,
  input  logic [`RSRC_CNT_W-1:0] i_ret_val,
  input  logic [`RSRC_CNT_W-1:0] i_limit,
  output logic [`RSRC_CNT_W-1:0] o_credits,
  output logic                   o_no_credits
);

  localparam int CNT_W = `RSRC_CNT_W;
  localparam logic [CNT_W-1:0] MAX_VAL = CNT_W'(MAX_CREDITS);

  logic [CNT_W-1:0] r_used;
  logic [CNT_W-1:0] w_used_next;
  logic [CNT_W-1:0] w_acq;
  logic [CNT_W-1:0] w_ret;
  logic [CNT_W-1:0] w_limit;

  // never allow more than the hardware depth, whatever the limit says
  assign w_limit = (i_limit > MAX_VAL) ? MAX_VAL : i_limit;

  assign w_acq = i_get_credit ? i_credit_val : '0;
  assign w_ret = i_ret_valid ? i_ret_val : '0;

  // acquire and return land together on the same edge
  assign w_used_next = r_used + w_acq - w_ret;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_used <= '0;
    end else begin
      r_used <= w_used_next;
    end
  end

  assign o_credits    = r_used;
  assign o_no_credits = (r_used >= w_limit);

endmodule

// File: source/brtag_alloc.sv
`timescale 1ns/1ps
`include "rsrc_defs.svh"

module brtag_alloc (
  input  logic                                          i_clk,
  input  logic                                          i_reset_n,
  input  logic                                          i_fire,
  input  logic [`RSRC_DISP_SIZE-1:0]                    i_br_vec,
  input  rsrc_pkg::commit_word_u                        i_commit,
  input  logic                                          i_br_upd_valid,
  input  logic [`RSRC_BRTAG_W-1:0]                      i_br_upd_tag,
  output logic [`RSRC_DISP_SIZE-1:0][`RSRC_BRTAG_W-1:0] o_brtag,
  output logic [`RSRC_DISP_SIZE-1:0][`RSRC_BRTAG_NUM-1:0] o_brmask
);

  import rsrc_pkg::*;

  localparam int DISP  = `RSRC_DISP_SIZE;
  localparam int NUM   = `RSRC_BRTAG_NUM;
  localparam int TAG_W = `RSRC_BRTAG_W;

  // tags in flight and the most recently handed out tag
  logic [NUM-1:0]   r_mask;
  logic [TAG_W-1:0] r_last_tag;

  logic [NUM-1:0]   w_free_vec;
  logic [NUM-1:0]   w_mask_rel;
  logic [NUM-1:0]   w_mask_chain [DISP+1];
  logic [TAG_W-1:0] w_tag_chain  [DISP+1];

  // ------------------------------
  // release
  // ------------------------------

  always_comb begin
    w_free_vec = '0;
    // committed branches
    if (i_commit.cmt.kind == KIND_COMMIT) begin
      for (int d = 0; d < DISP; d++) begin
        if (i_commit.cmt.is_br[d]) begin
          w_free_vec[i_commit.cmt.tag[d]] = 1'b1;
        end
      end
    end
    // flushed branch
    if (i_commit.flush.kind == KIND_FLUSH && i_commit.flush.valid) begin
      w_free_vec[i_commit.flush.tag] = 1'b1;
    end
    // resolved branch from the branch unit
    if (i_br_upd_valid) begin
      w_free_vec[i_br_upd_tag] = 1'b1;
    end
  end

  assign w_mask_rel = r_mask & ~w_free_vec;

  // ------------------------------
  // allocation, slot by slot
  // ------------------------------

  // computed from the branch vector alone so the tags show even under back-pressure
  always_comb begin
    logic             found;
    logic [TAG_W-1:0] idx;
    w_mask_chain[0] = w_mask_rel;
    w_tag_chain[0]  = r_last_tag;
    for (int d = 0; d < DISP; d++) begin
      // lowest free tag
      found = 1'b0;
      idx   = '0;
      for (int t = 0; t < NUM; t++) begin
        if (!found && !w_mask_chain[d][t]) begin
          found = 1'b1;
          idx   = TAG_W'(t);
        end
      end
      w_mask_chain[d+1] = w_mask_chain[d];
      w_tag_chain[d+1]  = w_tag_chain[d];
      if (i_br_vec[d] && found) begin
        w_mask_chain[d+1][idx] = 1'b1;
        w_tag_chain[d+1]       = idx;
      end
    end
  end

  for (genvar d = 0; d < DISP; d++) begin : g_slot_out
    assign o_brtag[d]  = w_tag_chain[d+1];
    // mask ahead of this slot, without its own tag
    assign o_brmask[d] = w_mask_chain[d];
  end

  // allocation only commits on a fired group, releases always apply
  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_mask     <= '0;
      r_last_tag <= '0;
    end else if (i_fire) begin
      r_mask     <= w_mask_chain[DISP];
      r_last_tag <= w_tag_chain[DISP];
    end else begin
      r_mask     <= w_mask_rel;
    end
  end

endmodule

// File: source/rsrc_alloc.sv
`timescale 1ns/1ps
`include "rsrc_defs.svh"

module rsrc_alloc (
  input  logic                                            i_clk,
  input  logic                                            i_reset_n,
  // dispatch group
  input  logic                                            i_disp_valid,
  input  logic                                            i_disp_ready,
  input  logic [`RSRC_CNT_W-1:0]                          i_disp_alu_cnt,
  input  logic [`RSRC_CNT_W-1:0]                          i_disp_ld_cnt,
  input  logic [`RSRC_CNT_W-1:0]                          i_disp_st_cnt,
  input  logic [`RSRC_DISP_SIZE-1:0]                      i_disp_br_vec,
  // commit and branch update
  input  rsrc_pkg::commit_word_u                          i_commit,
  input  logic                                            i_br_upd_valid,
  input  logic [`RSRC_BRTAG_W-1:0]                        i_br_upd_tag,
  // credit returns
  input  logic                                            i_rob_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_rob_ret_val,
  input  logic                                            i_alu_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_alu_ret_val,
  input  logic                                            i_ldq_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_ldq_ret_val,
  input  logic                                            i_stq_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_stq_ret_val,
  input  logic                                            i_bru_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_bru_ret_val,
  // limits from the config block
  input  logic [`RSRC_CNT_W-1:0]                          i_rob_limit,
  input  logic [`RSRC_CNT_W-1:0]                          i_alu_limit,
  input  logic [`RSRC_CNT_W-1:0]                          i_ldq_limit,
  input  logic [`RSRC_CNT_W-1:0]                          i_stq_limit,
  input  logic [`RSRC_CNT_W-1:0]                          i_bru_limit,
  output logic                                            o_resource_ok,
  output logic [`RSRC_DISP_SIZE-1:0][`RSRC_BRTAG_W-1:0]   o_brtag,
  output logic [`RSRC_DISP_SIZE-1:0][`RSRC_BRTAG_NUM-1:0] o_brmask
);

  import rsrc_pkg::*;

  localparam int DISP  = `RSRC_DISP_SIZE;
  localparam int CNT_W = `RSRC_CNT_W;
  // queue order is rob, alu, ldq, stq, bru
  localparam int NQ = 5;
  localparam int DEPTH [NQ] = '{`RSRC_ROB_DEPTH, `RSRC_ALU_DEPTH, `RSRC_LDQ_DEPTH,
                                `RSRC_STQ_DEPTH, `RSRC_BRU_DEPTH};

  logic w_flush_valid;
  logic w_fire;
  logic [CNT_W-1:0] w_bru_cnt;

  logic [NQ-1:0]            w_get;
  logic [NQ-1:0][CNT_W-1:0] w_acq_cnt;
  logic [NQ-1:0]            w_ret_valid;
  logic [NQ-1:0][CNT_W-1:0] w_ret_val;
  logic [NQ-1:0][CNT_W-1:0] w_limit;
  logic [NQ-1:0]            w_no_credits;

  // ------------------------------
  // fire gating
  // ------------------------------

  assign w_flush_valid = (i_commit.flush.kind == KIND_FLUSH) & i_commit.flush.valid;
  assign w_fire        = i_disp_valid & i_disp_ready & ~w_flush_valid;

  // one bru entry per branch slot
  always_comb begin
    w_bru_cnt = '0;
    for (int d = 0; d < DISP; d++) begin
      w_bru_cnt = w_bru_cnt + CNT_W'(i_disp_br_vec[d]);
    end
  end

  // ------------------------------
  // credit counters
  // ------------------------------

  // rob always takes one entry per group
  assign w_get = {w_fire & (|w_bru_cnt),
                  w_fire & (|i_disp_st_cnt),
                  w_fire & (|i_disp_ld_cnt),
                  w_fire & (|i_disp_alu_cnt),
                  w_fire};
  assign w_acq_cnt = {w_bru_cnt, i_disp_st_cnt, i_disp_ld_cnt, i_disp_alu_cnt, CNT_W'(1)};

  assign w_ret_valid = {i_bru_ret_valid, i_stq_ret_valid, i_ldq_ret_valid,
                        i_alu_ret_valid, i_rob_ret_valid};
  assign w_ret_val   = {i_bru_ret_val, i_stq_ret_val, i_ldq_ret_val,
                        i_alu_ret_val, i_rob_ret_val};
  assign w_limit     = {i_bru_limit, i_stq_limit, i_ldq_limit, i_alu_limit, i_rob_limit};

  for (genvar q = 0; q < NQ; q++) begin : g_credit
    credit_counter #(
      .MAX_CREDITS (DEPTH[q])
    ) u_credit_counter (
      .i_clk        (i_clk),
      .i_reset_n    (i_reset_n),
      .i_get_credit (w_get[q]),
      .i_credit_val (w_acq_cnt[q]),
      .i_ret_valid  (w_ret_valid[q]),
      .i_ret_val    (w_ret_val[q]),
      .i_limit      (w_limit[q]),
      .o_credits    (),
      .o_no_credits (w_no_credits[q])
    );
  end

  assign o_resource_ok = ~(|w_no_credits);

  // ------------------------------
  // branch tags
  // ------------------------------

  brtag_alloc u_brtag_alloc (
    .i_clk          (i_clk),
    .i_reset_n      (i_reset_n),
    .i_fire         (w_fire),
    .i_br_vec       (i_disp_br_vec),
    .i_commit       (i_commit),
    .i_br_upd_valid (i_br_upd_valid),
    .i_br_upd_tag   (i_br_upd_tag),
    .o_brtag        (o_brtag),
    .o_brmask       (o_brmask)
  );

endmodule

// File: source/rsrc_alloc_top.sv
`timescale 1ns/1ps
`include "rsrc_defs.svh"

module rsrc_alloc_top (
  input  logic                                            i_clk,
  input  logic                                            i_reset_n,
  input  logic                                            i_disp_valid,
  input  logic                                            i_disp_ready,
  input  logic [`RSRC_CNT_W-1:0]                          i_disp_alu_cnt,
  input  logic [`RSRC_CNT_W-1:0]                          i_disp_ld_cnt,
  input  logic [`RSRC_CNT_W-1:0]                          i_disp_st_cnt,
  input  logic [`RSRC_DISP_SIZE-1:0]                      i_disp_br_vec,
  input  rsrc_pkg::commit_word_u                          i_commit,
  input  logic                                            i_br_upd_valid,
  input  logic [`RSRC_BRTAG_W-1:0]                        i_br_upd_tag,
  input  logic                                            i_rob_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_rob_ret_val,
  input  logic                                            i_alu_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_alu_ret_val,
  input  logic                                            i_ldq_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_ldq_ret_val,
  input  logic                                            i_stq_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_stq_ret_val,
  input  logic                                            i_bru_ret_valid,
  input  logic [`RSRC_CNT_W-1:0]                          i_bru_ret_val,
  // config write port
  input  logic                                            i_cfg_we,
  input  logic [`RSRC_CFG_ADDR_W-1:0]                     i_cfg_addr,
  input  logic [`RSRC_CNT_W-1:0]                          i_cfg_wdata,
  output logic                                            o_resource_ok,
  output logic [`RSRC_DISP_SIZE-1:0][`RSRC_BRTAG_W-1:0]   o_brtag,
  output logic [`RSRC_DISP_SIZE-1:0][`RSRC_BRTAG_NUM-1:0] o_brmask
);

  logic [`RSRC_CNT_W-1:0] w_rob_limit;
  logic [`RSRC_CNT_W-1:0] w_alu_limit;
  logic [`RSRC_CNT_W-1:0] w_ldq_limit;
  logic [`RSRC_CNT_W-1:0] w_stq_limit;
  logic [`RSRC_CNT_W-1:0] w_bru_limit;

  rsrc_cfg_regs u_rsrc_cfg_regs (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_cfg_we    (i_cfg_we),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_wdata (i_cfg_wdata),
    .o_rob_limit (w_rob_limit),
    .o_alu_limit (w_alu_limit),
    .o_ldq_limit (w_ldq_limit),
    .o_stq_limit (w_stq_limit),
    .o_bru_limit (w_bru_limit)
  );

  rsrc_alloc u_rsrc_alloc (
    .i_clk           (i_clk),
    .i_reset_n       (i_reset_n),
    .i_disp_valid    (i_disp_valid),
    .i_disp_ready    (i_disp_ready),
    .i_disp_alu_cnt  (i_disp_alu_cnt),
    .i_disp_ld_cnt   (i_disp_ld_cnt),
    .i_disp_st_cnt   (i_disp_st_cnt),
    .i_disp_br_vec   (i_disp_br_vec),
    .i_commit        (i_commit),
    .i_br_upd_valid  (i_br_upd_valid),
    .i_br_upd_tag    (i_br_upd_tag),
    .i_rob_ret_valid (i_rob_ret_valid),
    .i_rob_ret_val   (i_rob_ret_val),
    .i_alu_ret_valid (i_alu_ret_valid),
    .i_alu_ret_val   (i_alu_ret_val),
    .i_ldq_ret_valid (i_ldq_ret_valid),
    .i_ldq_ret_val   (i_ldq_ret_val),
    .i_stq_ret_valid (i_stq_ret_valid),
    .i_stq_ret_val   (i_stq_ret_val),
    .i_bru_ret_valid (i_bru_ret_valid),
    .i_bru_ret_val   (i_bru_ret_val),
    .i_rob_limit     (w_rob_limit),
    .i_alu_limit     (w_alu_limit),
    .i_ldq_limit     (w_ldq_limit),
    .i_stq_limit     (w_stq_limit),
    .i_bru_limit     (w_bru_limit),
    .o_resource_ok   (o_resource_ok),
    .o_brtag         (o_brtag),
    .o_brmask        (o_brmask)
  );

endmodule

// File: sim/rsrc_alloc_sva.sv
`timescale 1ns/1ps
`include "rsrc_defs.svh"

module rsrc_alloc_sva (
  input logic                       i_clk,
  input logic                       i_reset_n,
  input logic                       i_fire,
  input logic                       i_flush_valid,
  input logic [`RSRC_BRTAG_NUM-1:0] i_mask,
  input logic [`RSRC_CNT_W-1:0]     i_rob_used,
  input logic                       i_resource_ok
);

  int fail_cnt = 0;

  // ------------------------------
  // branch tag mask
  // ------------------------------

  // tags only get set by a fired group
  a_mask_no_gain: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    !i_fire |=> ((i_mask & ~$past(i_mask)) == '0))
    else begin
      $error("branch mask gained a tag without a fire");
      fail_cnt++;
    end

  // a flushed group acquires no rob entry
  a_no_fire_on_flush: assert property (@(posedge i_clk) disable iff (!i_reset_n)
    i_flush_valid |=> (i_rob_used <= $past(i_rob_used)))
    else begin
      $error("group fired while a flush was on the commit word");
      fail_cnt++;
    end

  // all credits free right out of reset
  a_ok_after_reset: assert property (@(posedge i_clk)
    $rose(i_reset_n) |-> i_resource_ok)
    else begin
      $error("resource ok low in the first cycle after reset");
      fail_cnt++;
    end

endmodule

bind rsrc_alloc rsrc_alloc_sva u_sva (
  .i_clk         (i_clk),
  .i_reset_n     (i_reset_n),
  .i_fire        (w_fire),
  .i_flush_valid (w_flush_valid),
  .i_mask        (u_brtag_alloc.r_mask),
  .i_rob_used    (g_credit[0].u_credit_counter.r_used),
  .i_resource_ok (o_resource_ok)
);

// File: sim/rsrc_alloc_tb.sv
`timescale 1ns/1ps
`include "rsrc_defs.svh"

module rsrc_alloc_tb;

  import rsrc_pkg::*;

  localparam int DISP  = `RSRC_DISP_SIZE;
  localparam int NUM   = `RSRC_BRTAG_NUM;
  localparam int TAG_W = `RSRC_BRTAG_W;
  localparam int CNT_W = `RSRC_CNT_W;

  typedef logic [DISP-1:0][TAG_W-1:0] tag_vec_t;
  typedef logic [DISP-1:0][NUM-1:0]   mask_vec_t;

  // one table row, inputs first, then expected outputs
  typedef struct packed {
    logic [3:0]       ctl;      // valid, ready, br_vec
    logic [CNT_W-1:0] alu;
    commit_word_u     cmt;
    logic [2:0]       upd;      // valid, tag
    logic [4:0]       ret_sel;  // bru, stq, ldq, alu, rob
    logic [CNT_W-1:0] ret_val;
    logic [8:0]       cfg;      // we, addr, wdata
    logic [2:0]       chk;      // mask, tag, ok
    logic             ok;
    tag_vec_t         tag;
    mask_vec_t        mask;
  } row_t;

  logic                               clk;
  logic                               reset_n;
  logic                               disp_valid;
  logic                               disp_ready;
  logic [CNT_W-1:0]                   alu_cnt;
  logic [CNT_W-1:0]                   ld_cnt;
  logic [CNT_W-1:0]                   st_cnt;
  logic [DISP-1:0]                    br_vec;
  commit_word_u                       commit;
  logic                               upd_valid;
  logic [TAG_W-1:0]                   upd_tag;
  logic [4:0]                         ret_valid;
  logic [CNT_W-1:0]                   ret_val;
  logic                               cfg_we;
  logic [`RSRC_CFG_ADDR_W-1:0]        cfg_addr;
  logic [CNT_W-1:0]                   cfg_wdata;
  logic                               resource_ok;
  tag_vec_t                           brtag;
  mask_vec_t                          brmask;

  row_t         rows [$];
  int           row_idx;
  int           cycle_cnt   = 0;
  int           cycle_limit = 1000;
  commit_word_u c_idle;
  commit_word_u c_rel01;
  commit_word_u c_flush2;

  rsrc_alloc_top dut (
    .i_clk           (clk),
    .i_reset_n       (reset_n),
    .i_disp_valid    (disp_valid),
    .i_disp_ready    (disp_ready),
    .i_disp_alu_cnt  (alu_cnt),
    .i_disp_ld_cnt   (ld_cnt),
    .i_disp_st_cnt   (st_cnt),
    .i_disp_br_vec   (br_vec),
    .i_commit        (commit),
    .i_br_upd_valid  (upd_valid),
    .i_br_upd_tag    (upd_tag),
    .i_rob_ret_valid (ret_valid[0]),
    .i_rob_ret_val   (ret_val),
    .i_alu_ret_valid (ret_valid[1]),
    .i_alu_ret_val   (ret_val),
    .i_ldq_ret_valid (ret_valid[2]),
    .i_ldq_ret_val   (ret_val),
    .i_stq_ret_valid (ret_valid[3]),
    .i_stq_ret_val   (ret_val),
    .i_bru_ret_valid (ret_valid[4]),
    .i_bru_ret_val   (ret_val),
    .i_cfg_we        (cfg_we),
    .i_cfg_addr      (cfg_addr),
    .i_cfg_wdata     (cfg_wdata),
    .o_resource_ok   (resource_ok),
    .o_brtag         (brtag),
    .o_brmask        (brmask)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ------------------------------
  // helpers
  // ------------------------------

  function automatic commit_word_u commit_release(input logic [DISP-1:0] is_br,
                                                  input tag_vec_t tags);
    commit_word_u w;
    w           = '0;
    w.cmt.kind  = KIND_COMMIT;
    w.cmt.is_br = is_br;
    w.cmt.tag   = tags;
    return w;
  endfunction

  function automatic commit_word_u commit_flush(input logic [TAG_W-1:0] tag);
    commit_word_u w;
    w             = '0;
    w.flush.kind  = KIND_FLUSH;
    w.flush.valid = 1'b1;
    w.flush.tag   = tag;
    return w;
  endfunction

  task automatic add_row(input logic [3:0] ctl, input logic [CNT_W-1:0] alu,
                         input commit_word_u cmt, input logic [2:0] upd,
                         input logic [4:0] ret_sel, input logic [CNT_W-1:0] rval,
                         input logic [8:0] cfg, input logic [2:0] chk, input logic ok,
                         input tag_vec_t tag, input mask_vec_t mask);
    rows.push_back(row_t'({ctl, alu, cmt, upd, ret_sel, rval, cfg, chk, ok, tag, mask}));
  endtask

  task automatic drive_row(input row_t r);
    disp_valid = r.ctl[3];
    disp_ready = r.ctl[2];
    br_vec     = r.ctl[1:0];
    alu_cnt    = r.alu;
    ld_cnt     = '0;
    st_cnt     = '0;
    commit     = r.cmt;
    upd_valid  = r.upd[2];
    upd_tag    = r.upd[1:0];
    ret_valid  = r.ret_sel;
    ret_val    = r.ret_val;
    cfg_we     = r.cfg[8];
    cfg_addr   = r.cfg[7:5];
    cfg_wdata  = r.cfg[4:0];
  endtask

  task automatic abort_run();
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_ok(input logic act, input logic exp);
    if (act !== exp) begin
      $display("ERROR: o_resource_ok got %h expected %h at row %0d", act, exp, row_idx);
      abort_run();
    end
  endtask

  task automatic check_brtag(input tag_vec_t act, input tag_vec_t exp);
    if (act !== exp) begin
      $display("ERROR: o_brtag got %h expected %h at row %0d", act, exp, row_idx);
      abort_run();
    end
  endtask

  task automatic check_brmask(input mask_vec_t act, input mask_vec_t exp);
    if (act !== exp) begin
      $display("ERROR: o_brmask got %h expected %h at row %0d", act, exp, row_idx);
      abort_run();
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout, the table did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // bound checker counts its failed assertions
  always @(negedge clk) begin
    if (dut.u_rsrc_alloc.u_sva.fail_cnt != 0) begin
      $display("an assertion in the bound checker failed at row %0d", row_idx);
      abort_run();
    end
  end

  // ------------------------------
  // stimulus table
  // ------------------------------

  task automatic fill_table();
    // ctl, alu, commit, upd, ret_sel, ret_val, cfg, chk, ok, {tag1,tag0}, {mask1,mask0}
    add_row('b0101, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h0, 'h10);
    add_row('b1111, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h4, 'h10);
    add_row('b0100, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h5, 'h33);
    // fill the pool, bru credits run out
    add_row('b1111, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'hE, 'h73);
    add_row('b0100, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 0, 'hF, 'hFF);
    add_row('b0101, 0, c_rel01,  'b000, 'b10000, 2, 'h000, 'b111, 0, 'h0, 'hDC);
    add_row('b1101, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h0, 'hDC);
    // flush cancels the group, then a branch update
    add_row('b1101, 0, c_flush2, 'b000, 'b00000, 0, 'h000, 'b111, 1, 'h5, 'hB9);
    add_row('b0100, 0, c_idle,   'b111, 'b10000, 2, 'h000, 'b111, 1, 'h0, 'h11);
    add_row('b0111, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h9, 'h31);
    // alu limit of 2
    add_row('b0100, 0, c_idle,   'b000, 'b00000, 0, 'h122, 'b111, 1, 'h0, 'h11);
    add_row('b1100, 2, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h0, 'h11);
    add_row('b0100, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b001, 0, 'h0, 'h11);
    add_row('b0100, 0, c_idle,   'b000, 'b00010, 2, 'h000, 'b001, 0, 'h0, 'h11);
    add_row('b0100, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h0, 'h11);
    // back-pressure
    add_row('b1011, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h9, 'h31);
    add_row('b1011, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h9, 'h31);
    add_row('b1011, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h9, 'h31);
    add_row('b1111, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'h9, 'h31);
    add_row('b0100, 0, c_idle,   'b000, 'b00000, 0, 'h000, 'b111, 1, 'hA, 'h77);
  endtask

  initial begin
    reset_n = 1'b0;
    drive_row('0);
    c_idle   = '0;
    c_rel01  = commit_release(2'b11, 4'h4);
    c_flush2 = commit_flush(2'd2);
    fill_table();
    cycle_limit = rows.size() * 4 + 50;
    repeat (4) @(posedge clk);
    #1 reset_n = 1'b1;
    foreach (rows[i]) begin
      row_idx = i;
      @(posedge clk);
      #1 drive_row(rows[i]);
      @(negedge clk);
      if (rows[i].chk[0]) check_ok(resource_ok, rows[i].ok);
      if (rows[i].chk[1]) check_brtag(brtag, rows[i].tag);
      if (rows[i].chk[2]) check_brmask(brmask, rows[i].mask);
    end
    @(posedge clk);
    #1 drive_row('0);
    @(posedge clk);
    if (dut.u_rsrc_alloc.u_sva.fail_cnt != 0) begin
      $display("%0d assertion failures", dut.u_rsrc_alloc.u_sva.fail_cnt);
      abort_run();
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

// File: rsrc_alloc.f
+incdir+include
source/rsrc_pkg.sv
source/rsrc_cfg_regs.sv
source/credit_counter.sv
source/brtag_alloc.sv
source/rsrc_alloc.sv
source/rsrc_alloc_top.sv
sim/rsrc_alloc_sva.sv
sim/rsrc_alloc_tb.sv

// File: Bender.yml
package:
  name: rsrc_alloc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/rsrc_pkg.sv
      - source/rsrc_cfg_regs.sv
      - source/credit_counter.sv
      - source/brtag_alloc.sv
      - source/rsrc_alloc.sv
      - source/rsrc_alloc_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/rsrc_alloc_sva.sv
      - sim/rsrc_alloc_tb.sv
